// ==== hw/demod_settings.svh ====
/*
 * Shared constants for the OFDM receive controller: ADC pacing, burst detection
 * thresholds and buffer sizes. Included by every RTL block that needs them.
 */
`ifndef DEMOD_SETTINGS_SVH
`define DEMOD_SETTINGS_SVH

// clock cycles per ADC sample
`define DEMOD_SAMPLE_PERIOD 32

// cycles from ADC start until the sample is captured
`define DEMOD_CONV_CYCLES 20

// burst detection, deviation floor and trigger level
`define DEMOD_ADC_THRESHOLD 8
`define DEMOD_SUM_THRESHOLD 128

// mid-scale code of the 10-bit converter
`define DEMOD_ADC_MID 512

// samples per FFT window
`define DEMOD_WINDOW_LEN 1024

// ring buffer words
`define DEMOD_RING_DEPTH 8192

// decode attempts per window, each one sample earlier
`define DEMOD_MAX_SHIFT 10

`endif

// ==== hw/demod_pkg.sv ====
/*
 * Types shared by the receive controller blocks. Referenced with scoped names.
 */
`default_nettype none

package demod_pkg;

    // raw unsigned converter code
    typedef logic [9:0] adc_sample_t;

    // index into the 8192-word sample ring
    typedef logic [12:0] ring_addr_t;

    // word index in the external FFT memory
    typedef logic [9:0] fft_addr_t;

    // complex word, real in the upper half and imaginary in the lower half
    typedef logic [31:0] fft_word_t;

    // detection accumulator
    typedef logic [15:0] detect_sum_t;

    // retry shift count
    typedef logic [3:0] shift_t;

    // window sequencer FSM
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        FFT_RUN,
        OFDM_RUN,
        JUDGE
    } seq_state_t;

endpackage

`default_nettype wire

// ==== hw/adc_sampler.sv ====
/*
 * Paces the external ADC, writes every sample into the ring and locates the
 * start of a burst. window_ready is raised once a full window is stored and
 * held until the sequencer takes it.
 */
`timescale 1ns/1ns
`default_nettype none

`include "demod_settings.svh"

module adc_sampler (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire demod_pkg::adc_sample_t  adc_data,
    input  wire logic                    window_take,
    output logic                         adc_start,
    output logic                         ring_we,
    output demod_pkg::ring_addr_t        ring_waddr,
    output demod_pkg::adc_sample_t       ring_wdata,
    output logic                         window_ready,
    output demod_pkg::ring_addr_t        detect_index
);

    localparam int CYC_W = $clog2(`DEMOD_SAMPLE_PERIOD);
    localparam int CNT_W = $clog2(`DEMOD_WINDOW_LEN) + 1;

    localparam logic [CYC_W-1:0] LAST_CYC    = CYC_W'(`DEMOD_SAMPLE_PERIOD - 1);
    // sample is registered here so the ring write lands at the conversion count
    localparam logic [CYC_W-1:0] CAPTURE_CYC = CYC_W'(`DEMOD_CONV_CYCLES - 1);
    localparam logic [CYC_W-1:0] WRITE_CYC   = CYC_W'(`DEMOD_CONV_CYCLES);
    localparam logic [CNT_W-1:0] WIN_LEN     = CNT_W'(`DEMOD_WINDOW_LEN);

    localparam demod_pkg::adc_sample_t ADC_MID = 10'(`DEMOD_ADC_MID);
    localparam demod_pkg::adc_sample_t ADC_THR = 10'(`DEMOD_ADC_THRESHOLD);
    localparam demod_pkg::detect_sum_t SUM_THR = 16'(`DEMOD_SUM_THRESHOLD);

    logic [CYC_W-1:0]       cycle;
    logic [CNT_W-1:0]       cnt;
    demod_pkg::ring_addr_t  index;
    demod_pkg::detect_sum_t detect_sum;
    demod_pkg::detect_sum_t sum_next;
    demod_pkg::adc_sample_t dev_raw;
    demod_pkg::adc_sample_t dev;
    logic                   capture;
    logic                   detect_hit;

    // distance from mid-scale, small values count as silence
    always_comb begin
        dev_raw    = (adc_data >= ADC_MID) ? adc_data - ADC_MID : ADC_MID - adc_data;
        dev        = (dev_raw >= ADC_THR) ? dev_raw : '0;
        sum_next   = detect_sum + demod_pkg::detect_sum_t'(dev);
        capture    = (cycle == CAPTURE_CYC);
        detect_hit = capture && (cnt == '0) && (sum_next >= SUM_THR);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle        <= '0;
            adc_start    <= 1'b0;
            ring_we      <= 1'b0;
            index        <= '0;
            cnt          <= '0;
            detect_sum   <= '0;
            window_ready <= 1'b0;
        end else begin
            cycle     <= (cycle == LAST_CYC) ? '0 : cycle + 1'b1;
            adc_start <= (cycle == LAST_CYC);
            ring_we   <= capture;

            if (capture) begin
                // ring index wraps on its own at 8192
                index <= index + 1'b1;
                if (cnt == '0) begin
                    if (sum_next >= SUM_THR) begin
                        cnt <= CNT_W'(1);
                    end else begin
                        detect_sum <= sum_next;
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end

            if (window_take) begin
                window_ready <= 1'b0;
            end
            // last sample of the window is being written in this cycle
            if (cycle == WRITE_CYC && cnt == WIN_LEN) begin
                window_ready <= 1'b1;
                cnt          <= '0;
                detect_sum   <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            ring_waddr <= index;
            ring_wdata <= adc_data;
        end
        if (detect_hit) begin
            detect_index <= index;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sample_ring_ram.sv ====
/*
 * Simple dual-port sample memory for the ring buffer. One write port from the
 * sampler and one read port with a single cycle of latency for the sequencer.
 */
`timescale 1ns/1ns
`default_nettype none

`include "demod_settings.svh"

module sample_ring_ram (
    input  wire logic                    clk,
    input  wire logic                    we,
    input  wire demod_pkg::ring_addr_t   waddr,
    input  wire demod_pkg::adc_sample_t  wdata,
    input  wire demod_pkg::ring_addr_t   raddr,
    output demod_pkg::adc_sample_t       rdata
);

    demod_pkg::adc_sample_t mem [`DEMOD_RING_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, maps to block RAM
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== hw/window_sequencer.sv ====
/*
 * Takes a ready window, copies it in bit-reversed order into the FFT memory,
 * then runs the external FFT and OFDM decoder. Failed decodes are retried with
 * the window start moved one sample earlier until a lock or a sync failure.
 */
`timescale 1ns/1ns
`default_nettype none

`include "demod_settings.svh"

module window_sequencer (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    window_ready,
    input  wire demod_pkg::ring_addr_t   detect_index,
    input  wire demod_pkg::adc_sample_t  ring_rdata,
    input  wire logic                    fft_finish,
    input  wire logic                    ofdm_finish,
    input  wire logic                    ofdm_success,
    output logic                         window_take,
    output demod_pkg::ring_addr_t        ring_raddr,
    output logic                         fft_we,
    output demod_pkg::fft_addr_t         fft_waddr,
    output demod_pkg::fft_word_t         fft_wdata,
    output logic                         fft_start,
    output logic                         fft_clear,
    output logic                         ofdm_start,
    output logic                         ofdm_clear,
    output logic                         lock_found,
    output demod_pkg::shift_t            lock_shift,
    output logic                         sync_fail
);

    localparam int RD_W = $clog2(`DEMOD_WINDOW_LEN) + 1;

    localparam logic [RD_W-1:0]       WIN_LEN    = RD_W'(`DEMOD_WINDOW_LEN);
    localparam demod_pkg::fft_addr_t  LAST_K     = 10'(`DEMOD_WINDOW_LEN - 1);
    localparam demod_pkg::shift_t     LAST_SHIFT = 4'(`DEMOD_MAX_SHIFT - 1);

    demod_pkg::seq_state_t state;
    demod_pkg::ring_addr_t base;
    demod_pkg::shift_t     shift;
    demod_pkg::ring_addr_t rd_addr;
    demod_pkg::fft_addr_t  issue_k;
    demod_pkg::fft_addr_t  data_k;
    logic [RD_W-1:0]       rd_idx;
    logic                  issue_go;
    logic                  issue_valid;
    logic                  data_valid;
    logic                  phase_started;
    logic                  decode_ok;

    function automatic demod_pkg::fft_addr_t bit_rev(input demod_pkg::fft_addr_t k);
        demod_pkg::fft_addr_t r;
        for (int i = 0; i < $bits(k); i++) begin
            r[i] = k[$bits(k) - 1 - i];
        end
        return r;
    endfunction

    // offset binary to signed real part, imaginary part zero
    function automatic demod_pkg::fft_word_t to_fft_word(input demod_pkg::adc_sample_t s);
        logic [15:0] re;
        re = {6'd0, s} - 16'(`DEMOD_ADC_MID);
        return {re, 16'h0000};
    endfunction

    assign window_take = (state == demod_pkg::IDLE) && window_ready;
    assign issue_go    = (state == demod_pkg::LOAD) && (rd_idx != WIN_LEN);
    // window start minus shift, wraps modulo ring depth
    assign rd_addr     = base - demod_pkg::ring_addr_t'(shift)
                         + demod_pkg::ring_addr_t'(bit_rev(rd_idx[9:0]));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= demod_pkg::IDLE;
            shift         <= '0;
            rd_idx        <= '0;
            issue_valid   <= 1'b0;
            data_valid    <= 1'b0;
            phase_started <= 1'b0;
            decode_ok     <= 1'b0;
            fft_we        <= 1'b0;
            fft_start     <= 1'b0;
            fft_clear     <= 1'b0;
            ofdm_start    <= 1'b0;
            ofdm_clear    <= 1'b0;
            lock_found    <= 1'b0;
            lock_shift    <= '0;
            sync_fail     <= 1'b0;
        end else begin
            fft_we     <= 1'b0;
            fft_start  <= 1'b0;
            fft_clear  <= 1'b0;
            ofdm_start <= 1'b0;
            ofdm_clear <= 1'b0;
            lock_found <= 1'b0;
            sync_fail  <= 1'b0;

            case (state)
                demod_pkg::IDLE: begin
                    if (window_ready) begin
                        shift  <= '0;
                        rd_idx <= '0;
                        state  <= demod_pkg::LOAD;
                    end
                end
                demod_pkg::LOAD: begin
                    // address, RAM read and FFT write form a three stage pipe
                    issue_valid <= issue_go;
                    if (issue_go) begin
                        rd_idx <= rd_idx + 1'b1;
                    end
                    data_valid <= issue_valid;
                    fft_we     <= data_valid;
                    if (data_valid && data_k == LAST_K) begin
                        state <= demod_pkg::FFT_RUN;
                    end
                end
                demod_pkg::FFT_RUN: begin
                    if (!phase_started) begin
                        fft_start     <= 1'b1;
                        phase_started <= 1'b1;
                    end else if (fft_finish) begin
                        fft_clear     <= 1'b1;
                        phase_started <= 1'b0;
                        state         <= demod_pkg::OFDM_RUN;
                    end
                end
                demod_pkg::OFDM_RUN: begin
                    if (!phase_started) begin
                        ofdm_start    <= 1'b1;
                        phase_started <= 1'b1;
                    end else if (ofdm_finish) begin
                        ofdm_clear    <= 1'b1;
                        decode_ok     <= ofdm_success;
                        phase_started <= 1'b0;
                        state         <= demod_pkg::JUDGE;
                    end
                end
                demod_pkg::JUDGE: begin
                    if (decode_ok) begin
                        lock_found <= 1'b1;
                        lock_shift <= shift;
                        state      <= demod_pkg::IDLE;
                    end else if (shift == LAST_SHIFT) begin
                        sync_fail <= 1'b1;
                        state     <= demod_pkg::IDLE;
                    end else begin
                        // retry one sample earlier, same window
                        shift  <= shift + 1'b1;
                        rd_idx <= '0;
                        state  <= demod_pkg::LOAD;
                    end
                end
                default: begin
                    state <= demod_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (window_take) begin
            base <= detect_index;
        end
        if (issue_go) begin
            ring_raddr <= rd_addr;
            issue_k    <= rd_idx[9:0];
        end
        data_k <= issue_k;
        if (data_valid) begin
            fft_waddr <= data_k;
            fft_wdata <= to_fft_word(ring_rdata);
        end
    end

endmodule

`default_nettype wire

// ==== hw/ofdm_demod_top.sv ====
/*
 * Receive controller top level. Connects the ADC sampler, the sample ring and
 * the window sequencer; the FFT, decoder and ADC themselves sit outside.
 */
`timescale 1ns/1ns
`default_nettype none

module ofdm_demod_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire demod_pkg::adc_sample_t  adc_data,
    input  wire logic                    fft_finish,
    input  wire logic                    ofdm_finish,
    input  wire logic                    ofdm_success,
    output logic                         adc_start,
    output logic                         fft_we,
    output demod_pkg::fft_addr_t         fft_waddr,
    output demod_pkg::fft_word_t         fft_wdata,
    output logic                         fft_start,
    output logic                         fft_clear,
    output logic                         ofdm_start,
    output logic                         ofdm_clear,
    output logic                         lock_found,
    output demod_pkg::shift_t            lock_shift,
    output logic                         sync_fail
);

    logic                   ring_we;
    demod_pkg::ring_addr_t  ring_waddr;
    demod_pkg::adc_sample_t ring_wdata;
    demod_pkg::ring_addr_t  ring_raddr;
    demod_pkg::adc_sample_t ring_rdata;
    logic                   window_ready;
    logic                   window_take;
    demod_pkg::ring_addr_t  detect_index;

    adc_sampler u_sampler (
        .clk          (clk),
        .rst_n        (rst_n),
        .adc_data     (adc_data),
        .window_take  (window_take),
        .adc_start    (adc_start),
        .ring_we      (ring_we),
        .ring_waddr   (ring_waddr),
        .ring_wdata   (ring_wdata),
        .window_ready (window_ready),
        .detect_index (detect_index)
    );

    sample_ring_ram u_ring (
        .clk   (clk),
        .we    (ring_we),
        .waddr (ring_waddr),
        .wdata (ring_wdata),
        .raddr (ring_raddr),
        .rdata (ring_rdata)
    );

    window_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .window_ready (window_ready),
        .detect_index (detect_index),
        .ring_rdata   (ring_rdata),
        .fft_finish   (fft_finish),
        .ofdm_finish  (ofdm_finish),
        .ofdm_success (ofdm_success),
        .window_take  (window_take),
        .ring_raddr   (ring_raddr),
        .fft_we       (fft_we),
        .fft_waddr    (fft_waddr),
        .fft_wdata    (fft_wdata),
        .fft_start    (fft_start),
        .fft_clear    (fft_clear),
        .ofdm_start   (ofdm_start),
        .ofdm_clear   (ofdm_clear),
        .lock_found   (lock_found),
        .lock_shift   (lock_shift),
        .sync_fail    (sync_fail)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
/*
 * Testbench clock and reset source. 10 ns clock, reset held low for the
 * first 16 rising edges and released just after an edge.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    always #5 clk = ~clk;

endmodule

`default_nettype wire

// ==== dv/ofdm_demod_asserts.sv ====
/*
 * Concurrent checks on the window sequencer pulses and on FFT memory
 * ownership. Bound into the sequencer at the end of this file.
 */
`timescale 1ns/1ns
`default_nettype none

module ofdm_demod_asserts (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic fft_we,
    input wire logic fft_start,
    input wire logic fft_clear,
    input wire logic ofdm_start,
    input wire logic lock_found,
    input wire logic sync_fail
);

    logic fft_busy;
    int   fail_count;

    // FFT owns its memory from start until clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fft_busy <= 1'b0;
        end else if (fft_start) begin
            fft_busy <= 1'b1;
        end else if (fft_clear) begin
            fft_busy <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) fft_start |=> !fft_start)
        else begin
            $error("fft_start is wider than one cycle");
            fail_count++;
        end
    assert property (@(posedge clk) disable iff (!rst_n) ofdm_start |=> !ofdm_start)
        else begin
            $error("ofdm_start is wider than one cycle");
            fail_count++;
        end
    assert property (@(posedge clk) disable iff (!rst_n) lock_found |=> !lock_found)
        else begin
            $error("lock_found is wider than one cycle");
            fail_count++;
        end
    assert property (@(posedge clk) disable iff (!rst_n) sync_fail |=> !sync_fail)
        else begin
            $error("sync_fail is wider than one cycle");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) (fft_start || fft_busy) |-> !fft_we)
        else begin
            $error("fft_we raised while the FFT is running");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) !(lock_found && sync_fail))
        else begin
            $error("lock_found and sync_fail in the same cycle");
            fail_count++;
        end

endmodule

bind window_sequencer ofdm_demod_asserts asserts0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .fft_we     (fft_we),
    .fft_start  (fft_start),
    .fft_clear  (fft_clear),
    .ofdm_start (ofdm_start),
    .lock_found (lock_found),
    .sync_fail  (sync_fail)
);

`default_nettype wire

// ==== dv/ofdm_demod_tb.sv ====
/*
 * Testbench for the OFDM receive controller. Plays the scenarios of the cases
 * file through ADC, FFT and decoder models and checks every FFT load.
 */
`timescale 1ns/1ns
`default_nettype none

`include "demod_settings.svh"

module ofdm_demod_tb;

    localparam int BURST_LEN = 1000;

    logic                   clk;
    logic                   rst_n;
    demod_pkg::adc_sample_t adc_data;
    logic                   fft_finish;
    logic                   ofdm_finish;
    logic                   ofdm_success;
    logic                   adc_start;
    logic                   fft_we;
    demod_pkg::fft_addr_t   fft_waddr;
    demod_pkg::fft_word_t   fft_wdata;
    logic                   fft_start;
    logic                   fft_clear;
    logic                   ofdm_start;
    logic                   ofdm_clear;
    logic                   lock_found;
    demod_pkg::shift_t      lock_shift;
    logic                   sync_fail;

    // reference model of the ring and the detector
    logic [31:0]            lfsr;
    demod_pkg::adc_sample_t ring_model [`DEMOD_RING_DEPTH];
    int                     window_q [$];
    int sample_cnt, det_sum, det_cnt, det_index;
    int quiet_left, burst_left, noise_amp, burst_amp, fails_left;
    int cur_base, writes, fft_starts, ofdm_starts, locks, syncs, last_shift;
    int fft_clears, ofdm_clears, start_gap;
    int fft_runs, ofdm_runs, test_errors, errors, tests_run, tests_failed;
    bit    aborted;
    string case_name;

    tb_clock_gen clock0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ofdm_demod_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .adc_data     (adc_data),
        .fft_finish   (fft_finish),
        .ofdm_finish  (ofdm_finish),
        .ofdm_success (ofdm_success),
        .adc_start    (adc_start),
        .fft_we       (fft_we),
        .fft_waddr    (fft_waddr),
        .fft_wdata    (fft_wdata),
        .fft_start    (fft_start),
        .fft_clear    (fft_clear),
        .ofdm_start   (ofdm_start),
        .ofdm_clear   (ofdm_clear),
        .lock_found   (lock_found),
        .lock_shift   (lock_shift),
        .sync_fail    (sync_fail)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic int take_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    // amplitude stays below mid-scale in the cases file
    function automatic demod_pkg::adc_sample_t next_sample(input int amp);
        int mag;
        int v;
        mag = take_bits(9) % (amp + 1);
        v = (take_bits(1) != 0) ? `DEMOD_ADC_MID + mag : `DEMOD_ADC_MID - mag;
        return 10'(v);
    endfunction

    function automatic int bit_reverse(input int k);
        int r;
        r = 0;
        for (int i = 0; i < 10; i++) begin
            r = (r << 1) | ((k >> i) & 1);
        end
        return r;
    endfunction

    // store at the ring index and apply the burst detection rule
    task automatic record_sample(input demod_pkg::adc_sample_t s);
        int idx;
        int dev;
        idx = sample_cnt % `DEMOD_RING_DEPTH;
        ring_model[idx] = s;
        sample_cnt++;
        dev = int'(s) - `DEMOD_ADC_MID;
        dev = (dev < 0) ? -dev : dev;
        dev = (dev < `DEMOD_ADC_THRESHOLD) ? 0 : dev;
        if (det_cnt == 0) begin
            if (det_sum + dev >= `DEMOD_SUM_THRESHOLD) begin
                det_index = idx;
                det_cnt   = 1;
            end else begin
                det_sum += dev;
            end
        end else begin
            det_cnt++;
            if (det_cnt == `DEMOD_WINDOW_LEN) begin
                window_q.push_back(det_index);
                det_cnt = 0;
                det_sum = 0;
            end
        end
    endtask

    task automatic report_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("Error %0s %0s expected %0h actual %0h", case_name, what, expected, actual);
        test_errors++;
    endtask

    task automatic report_issue(input string msg);
        $display("%0s: %0s", case_name, msg);
        test_errors++;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else report_value(what, expected, actual);
    endtask

    // word k of a load holds the centred ring sample at base - shift + reverse(k)
    task automatic check_write(input int shift, input int k);
        int          idx;
        logic [31:0] exp_word;
        idx = (cur_base - shift + bit_reverse(k) + `DEMOD_RING_DEPTH) % `DEMOD_RING_DEPTH;
        exp_word = {16'(int'(ring_model[idx]) - `DEMOD_ADC_MID), 16'h0000};
        check_value("fft_waddr", k, 32'(fft_waddr));
        check_value("fft_wdata", exp_word, fft_wdata);
    endtask

    // ADC model gives a new conversion result after each start pulse
    always @(posedge clk) begin
        if (adc_start) begin
            #1;
            if (quiet_left > 0) begin
                quiet_left--;
                adc_data = next_sample(noise_amp);
            end else if (burst_left > 0) begin
                burst_left--;
                adc_data = next_sample(burst_amp);
            end else begin
                adc_data = next_sample(noise_amp);
            end
            record_sample(adc_data);
        end
    end

    always @(posedge clk) begin
        if (fft_start) begin
            fft_runs++;
            repeat (4 + 3 * (fft_runs % 5)) @(posedge clk);
            #1 fft_finish = 1'b1;
        end else if (fft_clear) begin
            #1 fft_finish = 1'b0;
        end
    end

    // decoder fails as often as the scenario asks, then succeeds
    always @(posedge clk) begin
        if (ofdm_start) begin
            ofdm_runs++;
            repeat (3 + 2 * (ofdm_runs % 4)) @(posedge clk);
            #1;
            ofdm_success = (fails_left == 0);
            fails_left   = (fails_left > 0) ? fails_left - 1 : 0;
            ofdm_finish  = 1'b1;
        end else if (ofdm_clear) begin
            #1;
            ofdm_finish  = 1'b0;
            ofdm_success = 1'b0;
        end
    end

    always @(posedge clk) begin
        // one conversion per sample period
        if (adc_start) begin
            if (start_gap >= 0) begin
                check_value("adc_start period", `DEMOD_SAMPLE_PERIOD, start_gap);
            end
            start_gap = 0;
        end
        if (start_gap >= 0) begin
            start_gap++;
        end
        if (fft_we) begin
            if (writes == 0) begin
                assert (window_q.size() > 0)
                    else report_issue("FFT load started without a detected burst");
                if (window_q.size() > 0) begin
                    cur_base = window_q.pop_front();
                end
            end
            check_write(writes / `DEMOD_WINDOW_LEN, writes % `DEMOD_WINDOW_LEN);
            writes++;
        end
        if (fft_start) begin
            fft_starts++;
            check_value("words before fft_start", fft_starts * `DEMOD_WINDOW_LEN, writes);
        end
        if (fft_clear) begin
            fft_clears++;
        end
        if (ofdm_start) begin
            ofdm_starts++;
        end
        if (ofdm_clear) begin
            ofdm_clears++;
        end
        if (lock_found) begin
            locks++;
            last_shift = int'(lock_shift);
        end
        if (sync_fail) begin
            syncs++;
        end
    end

    task automatic wait_reset();
        for (int t = 0; t < 100 && !rst_n; t++) begin
            @(posedge clk);
        end
        assert (rst_n) else report_issue("reset was never released");
        aborted = !rst_n;
    endtask

    task automatic run_case(input int quiet, input int noise, input int amp, input int fails);
        int limit;
        int loads;
        int target;
        int asserts_before;
        bit done;
        test_errors    = 0;
        writes         = 0;
        fft_starts     = 0;
        fft_clears     = 0;
        ofdm_starts    = 0;
        ofdm_clears    = 0;
        locks          = 0;
        syncs          = 0;
        fails_left     = fails;
        noise_amp      = noise;
        burst_amp      = amp;
        burst_left     = (amp > 0) ? BURST_LEN : 0;
        quiet_left     = quiet;
        done           = 1'b0;
        asserts_before = dut0.u_seq.asserts0.fail_count;
        if (amp == 0) begin
            target = sample_cnt + quiet;
            limit  = (quiet + 4) * `DEMOD_SAMPLE_PERIOD;
            for (int t = 0; t < limit && !done; t++) begin
                @(posedge clk);
                done = (sample_cnt >= target);
            end
            assert (done) else report_issue("timed out waiting for the quiet samples");
            check_value("fft writes", 0, writes);
            check_value("fft_start count", 0, fft_starts);
            check_value("model windows", 0, window_q.size());
        end else begin
            limit = (quiet + 2000) * `DEMOD_SAMPLE_PERIOD;
            for (int t = 0; t < limit && !done; t++) begin
                @(posedge clk);
                done = lock_found || sync_fail;
            end
            assert (done) else report_issue("timed out waiting for lock_found or sync_fail");
            // let the monitor count the final pulse
            repeat (2) @(posedge clk);
            loads = (fails >= `DEMOD_MAX_SHIFT) ? `DEMOD_MAX_SHIFT : fails + 1;
            check_value("fft words", loads * `DEMOD_WINDOW_LEN, writes);
            check_value("fft_start count", loads, fft_starts);
            check_value("fft_clear count", loads, fft_clears);
            check_value("ofdm_start count", loads, ofdm_starts);
            check_value("ofdm_clear count", loads, ofdm_clears);
            check_value("lock_found count", (fails >= `DEMOD_MAX_SHIFT) ? 0 : 1, locks);
            check_value("sync_fail count", (fails >= `DEMOD_MAX_SHIFT) ? 1 : 0, syncs);
            if (fails < `DEMOD_MAX_SHIFT) begin
                check_value("lock_shift", fails, last_shift);
            end
        end
        assert (dut0.u_seq.asserts0.fail_count == asserts_before)
            else report_issue("a sequencer protocol assertion failed");
        aborted = !done;
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        errors += test_errors;
        $display("%0s %0s", case_name, (test_errors == 0) ? "passed" : "FAILED");
    endtask

    task automatic finish_run();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_run > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    initial begin
        int    fd;
        int    n;
        int    quiet;
        int    noise;
        int    amp;
        int    fails;
        string line;
        adc_data     = 10'(`DEMOD_ADC_MID);
        fft_finish   = 1'b0;
        ofdm_finish  = 1'b0;
        ofdm_success = 1'b0;
        lfsr         = 32'h3872_ba16;
        start_gap    = -1;
        case_name    = "setup";
        // the level present at the first capture is ring index 0
        record_sample(adc_data);
        fd = $fopen("dv/ofdm_demod_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the cases file");
            errors++;
        end else begin
            wait_reset();
            while (!$feof(fd) && !aborted) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %d %d %d %d", case_name, quiet, noise, amp, fails);
                    if (n == 5) begin
                        run_case(quiet, noise, amp, fails);
                    end
                end
            end
            $fclose(fd);
        end
        errors += aborted ? 1 : 0;
        finish_run();
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/demod_pkg.sv
hw/adc_sampler.sv
hw/sample_ring_ram.sv
hw/window_sequencer.sv
hw/ofdm_demod_top.sv
dv/tb_clock_gen.sv
dv/ofdm_demod_asserts.sv
dv/ofdm_demod_tb.sv

// ==== dv/ofdm_demod_cases.txt ====
# name quiet_samples noise_amplitude burst_amplitude failed_decodes
# burst amplitude 0 means no burst, 10 or more failed decodes means never
quiet_line 400 7 0 0
first_lock 120 5 200 0
retry_three 90 7 300 3
retry_nine 60 3 250 9
never_sync 150 6 280 12
after_fail 100 4 220 1
wide_burst 200 7 400 2
tail_quiet 150 6 0 0
